/* all.f */
rtl/rv_pkg.sv
rtl/fetch_stage.sv
rtl/register_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/cpu_core.sv
tb/tb_mem_model.sv
tb/tb_cpu_core.sv

/* rtl/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core (
    input  logic                      clk,
    input  logic                      rst_n,
    output logic [rv_pkg::xlen-1:0]   imem_addr,
    input  logic [rv_pkg::inst_w-1:0] imem_data,
    input  logic                      imem_ready,
    output logic [rv_pkg::xlen-1:0]   dmem_addr,
    output logic [rv_pkg::xlen-1:0]   dmem_wdata,
    output logic                      dmem_read,
    output logic                      dmem_write,
    input  logic [rv_pkg::xlen-1:0]   dmem_rdata,
    input  logic                      dmem_ready
);

    logic                          mem_busy;
    logic                          load_stall;
    logic [rv_pkg::inst_w-1:0]     if_id_inst;
    logic                          if_id_valid;
    logic                          id_ex_valid;
    logic [rv_pkg::reg_addr_w-1:0] id_ex_rs1;
    logic [rv_pkg::reg_addr_w-1:0] id_ex_rs2;
    logic [rv_pkg::reg_addr_w-1:0] id_ex_rd;
    logic [rv_pkg::xlen-1:0]       id_ex_rs1_data;
    logic [rv_pkg::xlen-1:0]       id_ex_rs2_data;
    logic [rv_pkg::xlen-1:0]       id_ex_imm;
    logic [rv_pkg::alu_op_w-1:0]   id_ex_alu_op;
    logic                          id_ex_alu_src;
    logic                          id_ex_mem_read;
    logic                          id_ex_mem_write;
    logic                          id_ex_reg_write;
    logic                          ex_mem_valid;
    logic [rv_pkg::xlen-1:0]       ex_mem_result;
    logic [rv_pkg::xlen-1:0]       ex_mem_store_data;
    logic [rv_pkg::reg_addr_w-1:0] ex_mem_rd;
    logic                          ex_mem_mem_read;
    logic                          ex_mem_mem_write;
    logic                          ex_mem_reg_write;
    logic                          wb_we;
    logic [rv_pkg::reg_addr_w-1:0] wb_rd;
    logic [rv_pkg::xlen-1:0]       wb_data;

    fetch_stage u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .hold        (mem_busy),
        .load_stall  (load_stall),
        .imem_ready  (imem_ready),
        .imem_data   (imem_data),
        .imem_addr   (imem_addr),
        .if_id_inst  (if_id_inst),
        .if_id_valid (if_id_valid)
    );

    decode_stage u_decode (
        .clk             (clk),
        .rst_n           (rst_n),
        .hold            (mem_busy),
        .if_id_inst      (if_id_inst),
        .if_id_valid     (if_id_valid),
        .wb_we           (wb_we),
        .wb_rd           (wb_rd),
        .wb_data         (wb_data),
        .load_stall      (load_stall),
        .id_ex_valid     (id_ex_valid),
        .id_ex_rs1       (id_ex_rs1),
        .id_ex_rs2       (id_ex_rs2),
        .id_ex_rd        (id_ex_rd),
        .id_ex_rs1_data  (id_ex_rs1_data),
        .id_ex_rs2_data  (id_ex_rs2_data),
        .id_ex_imm       (id_ex_imm),
        .id_ex_alu_op    (id_ex_alu_op),
        .id_ex_alu_src   (id_ex_alu_src),
        .id_ex_mem_read  (id_ex_mem_read),
        .id_ex_mem_write (id_ex_mem_write),
        .id_ex_reg_write (id_ex_reg_write)
    );

    execute_stage u_execute (
        .clk               (clk),
        .rst_n             (rst_n),
        .hold              (mem_busy),
        .id_ex_valid       (id_ex_valid),
        .id_ex_rs1         (id_ex_rs1),
        .id_ex_rs2         (id_ex_rs2),
        .id_ex_rd          (id_ex_rd),
        .id_ex_rs1_data    (id_ex_rs1_data),
        .id_ex_rs2_data    (id_ex_rs2_data),
        .id_ex_imm         (id_ex_imm),
        .id_ex_alu_op      (id_ex_alu_op),
        .id_ex_alu_src     (id_ex_alu_src),
        .id_ex_mem_read    (id_ex_mem_read),
        .id_ex_mem_write   (id_ex_mem_write),
        .id_ex_reg_write   (id_ex_reg_write),
        .wb_we             (wb_we),
        .wb_rd             (wb_rd),
        .wb_data           (wb_data),
        .ex_mem_valid      (ex_mem_valid),
        .ex_mem_result     (ex_mem_result),
        .ex_mem_store_data (ex_mem_store_data),
        .ex_mem_rd         (ex_mem_rd),
        .ex_mem_mem_read   (ex_mem_mem_read),
        .ex_mem_mem_write  (ex_mem_mem_write),
        .ex_mem_reg_write  (ex_mem_reg_write)
    );

    memory_stage u_memory (
        .clk               (clk),
        .rst_n             (rst_n),
        .ex_mem_valid      (ex_mem_valid),
        .ex_mem_result     (ex_mem_result),
        .ex_mem_store_data (ex_mem_store_data),
        .ex_mem_rd         (ex_mem_rd),
        .ex_mem_mem_read   (ex_mem_mem_read),
        .ex_mem_mem_write  (ex_mem_mem_write),
        .ex_mem_reg_write  (ex_mem_reg_write),
        .dmem_rdata        (dmem_rdata),
        .dmem_ready        (dmem_ready),
        .dmem_addr         (dmem_addr),
        .dmem_wdata        (dmem_wdata),
        .dmem_read         (dmem_read),
        .dmem_write        (dmem_write),
        .mem_busy          (mem_busy),
        .wb_we             (wb_we),
        .wb_rd             (wb_rd),
        .wb_data           (wb_data)
    );

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            hold,
    input  logic [rv_pkg::inst_w-1:0]       if_id_inst,
    input  logic                            if_id_valid,
    input  logic                            wb_we,
    input  logic [rv_pkg::reg_addr_w-1:0]   wb_rd,
    input  logic [rv_pkg::xlen-1:0]         wb_data,
    output logic                            load_stall,
    output logic                            id_ex_valid,
    output logic [rv_pkg::reg_addr_w-1:0]   id_ex_rs1,
    output logic [rv_pkg::reg_addr_w-1:0]   id_ex_rs2,
    output logic [rv_pkg::reg_addr_w-1:0]   id_ex_rd,
    output logic [rv_pkg::xlen-1:0]         id_ex_rs1_data,
    output logic [rv_pkg::xlen-1:0]         id_ex_rs2_data,
    output logic [rv_pkg::xlen-1:0]         id_ex_imm,
    output logic [rv_pkg::alu_op_w-1:0]     id_ex_alu_op,
    output logic                            id_ex_alu_src,
    output logic                            id_ex_mem_read,
    output logic                            id_ex_mem_write,
    output logic                            id_ex_reg_write
);

    rv_pkg::inst_u                 inst;
    logic [rv_pkg::xlen-1:0]       rs1_data;
    logic [rv_pkg::xlen-1:0]       rs2_data;
    logic [rv_pkg::xlen-1:0]       imm_i;
    logic [rv_pkg::xlen-1:0]       imm_s;
    logic [rv_pkg::xlen-1:0]       imm;
    logic [rv_pkg::alu_op_w-1:0]   alu_op;
    logic                          legal;
    logic                          alu_src;
    logic                          mem_read;
    logic                          mem_write;
    logic                          reg_write;
    logic                          issue;

    assign inst = if_id_inst;

    register_file u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (inst.r.rs1),
        .rs2      (inst.r.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_we    (wb_we),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    assign imm_i = {{(rv_pkg::xlen-12){inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
    assign imm_s = {{(rv_pkg::xlen-12){inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};

    always_comb begin
        legal     = 1'b1;
        alu_src   = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        alu_op    = rv_pkg::alu_add;
        imm       = imm_i;
        case (inst.r.opcode)
            rv_pkg::op_op: begin
                reg_write = 1'b1;
                alu_op    = {inst.r.funct7[5], inst.r.funct3};
            end
            rv_pkg::op_op_imm: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                // Only SRAI keeps bit 30
                alu_op    = {(inst.i.funct3 == 3'b101) && inst.r.funct7[5], inst.i.funct3};
            end
            rv_pkg::op_load: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
                alu_src   = 1'b1;
            end
            rv_pkg::op_store: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
                imm       = imm_s;
            end
            default: legal = 1'b0; // Unsupported opcode becomes a bubble
        endcase
    end

    assign load_stall = id_ex_mem_read && id_ex_rd != '0 &&
                        (id_ex_rd == inst.r.rs1 || id_ex_rd == inst.r.rs2);
    assign issue = if_id_valid && legal && !load_stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex_valid     <= 1'b0;
            id_ex_mem_read  <= 1'b0;
            id_ex_mem_write <= 1'b0;
            id_ex_reg_write <= 1'b0;
        end else if (!hold) begin
            id_ex_valid     <= issue;
            id_ex_mem_read  <= issue && mem_read;
            id_ex_mem_write <= issue && mem_write;
            id_ex_reg_write <= issue && reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            id_ex_rs1      <= inst.r.rs1;
            id_ex_rs2      <= inst.r.rs2;
            id_ex_rd       <= inst.r.rd;
            id_ex_rs1_data <= rs1_data;
            id_ex_rs2_data <= rs2_data;
            id_ex_imm      <= imm;
            id_ex_alu_op   <= alu_op;
            id_ex_alu_src  <= alu_src;
        end
    end

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          hold,
    input  logic                          id_ex_valid,
    input  logic [rv_pkg::reg_addr_w-1:0] id_ex_rs1,
    input  logic [rv_pkg::reg_addr_w-1:0] id_ex_rs2,
    input  logic [rv_pkg::reg_addr_w-1:0] id_ex_rd,
    input  logic [rv_pkg::xlen-1:0]       id_ex_rs1_data,
    input  logic [rv_pkg::xlen-1:0]       id_ex_rs2_data,
    input  logic [rv_pkg::xlen-1:0]       id_ex_imm,
    input  logic [rv_pkg::alu_op_w-1:0]   id_ex_alu_op,
    input  logic                          id_ex_alu_src,
    input  logic                          id_ex_mem_read,
    input  logic                          id_ex_mem_write,
    input  logic                          id_ex_reg_write,
    input  logic                          wb_we,
    input  logic [rv_pkg::reg_addr_w-1:0] wb_rd,
    input  logic [rv_pkg::xlen-1:0]       wb_data,
    output logic                          ex_mem_valid,
    output logic [rv_pkg::xlen-1:0]       ex_mem_result,
    output logic [rv_pkg::xlen-1:0]       ex_mem_store_data,
    output logic [rv_pkg::reg_addr_w-1:0] ex_mem_rd,
    output logic                          ex_mem_mem_read,
    output logic                          ex_mem_mem_write,
    output logic                          ex_mem_reg_write
);

    logic [rv_pkg::xlen-1:0] op_a;
    logic [rv_pkg::xlen-1:0] rs2_fwd;
    logic [rv_pkg::xlen-1:0] op_b;
    logic [rv_pkg::xlen-1:0] result;
    logic [rv_pkg::shamt_w-1:0] shamt;

    // EX/MEM wins over writeback and x0 is never forwarded
    always_comb begin
        op_a = id_ex_rs1_data;
        if (ex_mem_reg_write && ex_mem_rd != '0 && ex_mem_rd == id_ex_rs1)
            op_a = ex_mem_result;
        else if (wb_we && wb_rd != '0 && wb_rd == id_ex_rs1)
            op_a = wb_data;
    end

    always_comb begin
        rs2_fwd = id_ex_rs2_data;
        if (ex_mem_reg_write && ex_mem_rd != '0 && ex_mem_rd == id_ex_rs2)
            rs2_fwd = ex_mem_result;
        else if (wb_we && wb_rd != '0 && wb_rd == id_ex_rs2)
            rs2_fwd = wb_data;
    end

    assign op_b    = id_ex_alu_src ? id_ex_imm : rs2_fwd;
    assign shamt   = op_b[rv_pkg::shamt_w-1:0];

    always_comb begin
        case (id_ex_alu_op)
            rv_pkg::alu_sub:  result = op_a - op_b;
            rv_pkg::alu_sll:  result = op_a << shamt;
            rv_pkg::alu_slt:  result = rv_pkg::xlen'($signed(op_a) < $signed(op_b));
            rv_pkg::alu_sltu: result = rv_pkg::xlen'(op_a < op_b);
            rv_pkg::alu_xor:  result = op_a ^ op_b;
            rv_pkg::alu_srl:  result = op_a >> shamt;
            rv_pkg::alu_sra:  result = $signed(op_a) >>> shamt;
            rv_pkg::alu_or:   result = op_a | op_b;
            rv_pkg::alu_and:  result = op_a & op_b;
            default:          result = op_a + op_b; // ADD and address calc
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem_valid     <= 1'b0;
            ex_mem_mem_read  <= 1'b0;
            ex_mem_mem_write <= 1'b0;
            ex_mem_reg_write <= 1'b0;
        end else if (!hold) begin
            ex_mem_valid     <= id_ex_valid;
            ex_mem_mem_read  <= id_ex_mem_read;
            ex_mem_mem_write <= id_ex_mem_write;
            ex_mem_reg_write <= id_ex_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            ex_mem_result     <= result;
            ex_mem_store_data <= rs2_fwd;
            ex_mem_rd         <= id_ex_rd;
        end
    end

endmodule

/* rtl/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      hold,
    input  logic                      load_stall,
    input  logic                      imem_ready,
    input  logic [rv_pkg::inst_w-1:0] imem_data,
    output logic [rv_pkg::xlen-1:0]   imem_addr,
    output logic [rv_pkg::inst_w-1:0] if_id_inst,
    output logic                      if_id_valid
);

    logic [rv_pkg::xlen-1:0] pc;
    logic                    advance;

    assign advance   = !hold && !load_stall;
    assign imem_addr = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc          <= '0;
            if_id_valid <= 1'b0;
        end else if (advance) begin
            if_id_valid <= imem_ready; // Bubble while memory not ready
            if (imem_ready)
                pc <= pc + rv_pkg::xlen'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (advance && imem_ready)
            if_id_inst <= imem_data;
    end

endmodule

/* rtl/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          ex_mem_valid,
    input  logic [rv_pkg::xlen-1:0]       ex_mem_result,
    input  logic [rv_pkg::xlen-1:0]       ex_mem_store_data,
    input  logic [rv_pkg::reg_addr_w-1:0] ex_mem_rd,
    input  logic                          ex_mem_mem_read,
    input  logic                          ex_mem_mem_write,
    input  logic                          ex_mem_reg_write,
    input  logic [rv_pkg::xlen-1:0]       dmem_rdata,
    input  logic                          dmem_ready,
    output logic [rv_pkg::xlen-1:0]       dmem_addr,
    output logic [rv_pkg::xlen-1:0]       dmem_wdata,
    output logic                          dmem_read,
    output logic                          dmem_write,
    output logic                          mem_busy,
    output logic                          wb_we,
    output logic [rv_pkg::reg_addr_w-1:0] wb_rd,
    output logic [rv_pkg::xlen-1:0]       wb_data
);

    logic                    mem_wb_valid;
    logic                    mem_wb_reg_write;
    logic                    mem_wb_mem_to_reg;
    logic [rv_pkg::xlen-1:0] mem_wb_result;
    logic [rv_pkg::xlen-1:0] mem_wb_load_data;

    assign dmem_addr  = ex_mem_result;
    assign dmem_wdata = ex_mem_store_data;
    assign dmem_read  = ex_mem_valid && ex_mem_mem_read;
    assign dmem_write = ex_mem_valid && ex_mem_mem_write;
    assign mem_busy   = (dmem_read || dmem_write) && !dmem_ready; // Freeze until ready

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb_valid     <= 1'b0;
            mem_wb_reg_write <= 1'b0;
        end else if (!mem_busy) begin
            mem_wb_valid     <= ex_mem_valid;
            mem_wb_reg_write <= ex_mem_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_busy) begin
            mem_wb_mem_to_reg <= ex_mem_mem_read;
            mem_wb_result     <= ex_mem_result;
            mem_wb_load_data  <= dmem_rdata; // Sampled on the ready cycle
            wb_rd             <= ex_mem_rd;
        end
    end

    assign wb_we   = mem_wb_valid && mem_wb_reg_write;
    assign wb_data = mem_wb_mem_to_reg ? mem_wb_load_data : mem_wb_result;

endmodule

/* rtl/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_pkg::reg_addr_w-1:0] rs1,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2,
    output logic [rv_pkg::xlen-1:0]       rs1_data,
    output logic [rv_pkg::xlen-1:0]       rs2_data,
    input  logic                          wb_we,
    input  logic [rv_pkg::reg_addr_w-1:0] wb_rd,
    input  logic [rv_pkg::xlen-1:0]       wb_data
);

    logic [rv_pkg::xlen-1:0] regs [rv_pkg::num_regs];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rv_pkg::num_regs; i++)
                regs[i] <= '0;
        end else if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Write-through covers a writer three instructions back
    assign rs1_data = (rs1 == '0) ? '0 :
                      (wb_we && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 :
                      (wb_we && wb_rd == rs2) ? wb_data : regs[rs2];

endmodule

/* rtl/rv_pkg.sv */
package rv_pkg;

    localparam int xlen       = 64;
    localparam int inst_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;
    localparam int shamt_w    = 6;
    localparam int alu_op_w   = 4;

    // Kept major opcodes
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_op_imm = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;

    // ALU op is {funct7[5], funct3}
    localparam logic [alu_op_w-1:0] alu_add  = 4'b0000;
    localparam logic [alu_op_w-1:0] alu_sub  = 4'b1000;
    localparam logic [alu_op_w-1:0] alu_sll  = 4'b0001;
    localparam logic [alu_op_w-1:0] alu_slt  = 4'b0010;
    localparam logic [alu_op_w-1:0] alu_sltu = 4'b0011;
    localparam logic [alu_op_w-1:0] alu_xor  = 4'b0100;
    localparam logic [alu_op_w-1:0] alu_srl  = 4'b0101;
    localparam logic [alu_op_w-1:0] alu_sra  = 4'b1101;
    localparam logic [alu_op_w-1:0] alu_or   = 4'b0110;
    localparam logic [alu_op_w-1:0] alu_and  = 4'b0111;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_4_0;
        logic [6:0]            opcode;
    } inst_s_t;

    // Three views of one instruction word
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_s_t s;
    } inst_u;

endpackage

/* tb/tb_cpu_core.sv */
`timescale 1ns/1ps

module tb_cpu_core;

    localparam int unsigned seed = 32'hb90da17f;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      random_ready;
    logic [rv_pkg::xlen-1:0]   imem_addr;
    logic [rv_pkg::inst_w-1:0] imem_data;
    logic                      imem_ready;
    logic [rv_pkg::xlen-1:0]   dmem_addr;
    logic [rv_pkg::xlen-1:0]   dmem_wdata;
    logic                      dmem_read;
    logic                      dmem_write;
    logic [rv_pkg::xlen-1:0]   dmem_rdata;
    logic                      dmem_ready;

    logic [rv_pkg::inst_w-1:0] prog [$];
    logic [rv_pkg::xlen-1:0]   exp_addr [$];
    logic [rv_pkg::xlen-1:0]   exp_data [$];
    logic [rv_pkg::xlen-1:0]   mregs [rv_pkg::num_regs]; // Reference register array
    logic [rv_pkg::xlen-1:0]   mram [64];
    int prog_len = 0;
    int exp_count = 0;
    int store_idx = 0;
    int checks = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    logic                    waiting = 1'b0;
    logic [rv_pkg::xlen-1:0] held_addr;
    logic [rv_pkg::xlen-1:0] held_wdata;
    logic                    held_read;
    logic                    held_write;

    always #20 clk = ~clk;

    cpu_core u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .imem_ready (imem_ready),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_read  (dmem_read),
        .dmem_write (dmem_write),
        .dmem_rdata (dmem_rdata),
        .dmem_ready (dmem_ready)
    );

    tb_mem_model #(.seed(seed)) u_mem (
        .clk          (clk),
        .random_ready (random_ready),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .imem_ready   (imem_ready),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_write   (dmem_write),
        .dmem_rdata   (dmem_rdata),
        .dmem_ready   (dmem_ready)
    );

    function automatic logic [63:0] sext12(input logic [11:0] imm);
        return {{52{imm[11]}}, imm};
    endfunction

    // ISA semantics of the ten ALU operations
    function automatic logic [63:0] alu_ref(input logic [3:0] op, input logic [63:0] a,
                                            input logic [63:0] b);
        case (op)
            rv_pkg::alu_add:  return a + b;
            rv_pkg::alu_sub:  return a - b;
            rv_pkg::alu_sll:  return a << b[5:0];
            rv_pkg::alu_slt:  return {63'd0, $signed(a) < $signed(b)};
            rv_pkg::alu_sltu: return {63'd0, a < b};
            rv_pkg::alu_xor:  return a ^ b;
            rv_pkg::alu_srl:  return a >> b[5:0];
            rv_pkg::alu_sra:  return $unsigned($signed(a) >>> b[5:0]);
            rv_pkg::alu_or:   return a | b;
            default:          return a & b;
        endcase
    endfunction

    task automatic set_reg(input logic [4:0] rd, input logic [63:0] value);
        if (rd != 5'd0)
            mregs[rd] = value;
    endtask

    task automatic alu_rr(input logic [3:0] op, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [4:0] rs2);
        rv_pkg::inst_u w;
        w.r.funct7 = {1'b0, op[3], 5'b0};
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = op[2:0];
        w.r.rd     = rd;
        w.r.opcode = rv_pkg::op_op;
        prog.push_back(w);
        set_reg(rd, alu_ref(op, mregs[rs1], mregs[rs2]));
    endtask

    task automatic alu_ri(input logic [3:0] op, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [11:0] imm);
        rv_pkg::inst_u w;
        if (op == rv_pkg::alu_sra)
            imm[10] = 1'b1; // SRAI marker bit
        w.i.imm_11_0 = imm;
        w.i.rs1      = rs1;
        w.i.funct3   = op[2:0];
        w.i.rd       = rd;
        w.i.opcode   = rv_pkg::op_op_imm;
        prog.push_back(w);
        set_reg(rd, alu_ref(op, mregs[rs1], sext12(imm)));
    endtask

    task automatic load_dword(input logic [4:0] rd, input logic [4:0] rs1,
                              input logic [11:0] imm);
        rv_pkg::inst_u w;
        logic [63:0]   addr;
        w.i.imm_11_0 = imm;
        w.i.rs1      = rs1;
        w.i.funct3   = 3'b011;
        w.i.rd       = rd;
        w.i.opcode   = rv_pkg::op_load;
        prog.push_back(w);
        addr = mregs[rs1] + sext12(imm);
        set_reg(rd, mram[addr[8:3]]);
    endtask

    task automatic store_dword(input logic [4:0] rs2, input logic [4:0] rs1,
                               input logic [11:0] imm);
        rv_pkg::inst_u w;
        logic [63:0]   addr;
        w.s.imm_11_5 = imm[11:5];
        w.s.rs2      = rs2;
        w.s.rs1      = rs1;
        w.s.funct3   = 3'b011;
        w.s.imm_4_0  = imm[4:0];
        w.s.opcode   = rv_pkg::op_store;
        prog.push_back(w);
        addr = mregs[rs1] + sext12(imm);
        exp_addr.push_back(addr);
        exp_data.push_back(mregs[rs2]);
        mram[addr[8:3]] = mregs[rs2];
    endtask

    task automatic build_program();
        logic [3:0]  r_ops [10] = '{rv_pkg::alu_add, rv_pkg::alu_sub, rv_pkg::alu_sll,
                                    rv_pkg::alu_slt, rv_pkg::alu_sltu, rv_pkg::alu_xor,
                                    rv_pkg::alu_srl, rv_pkg::alu_sra, rv_pkg::alu_or,
                                    rv_pkg::alu_and};
        logic [3:0]  i_ops [9]  = '{rv_pkg::alu_add, rv_pkg::alu_slt, rv_pkg::alu_sltu,
                                    rv_pkg::alu_xor, rv_pkg::alu_or, rv_pkg::alu_and,
                                    rv_pkg::alu_sll, rv_pkg::alu_srl, rv_pkg::alu_sra};
        logic [11:0] i_imms [9] = '{12'hf9c, 12'hffb, 12'hfff, 12'hfff, 12'h0f0, 12'h7ff,
                                    12'd37, 12'd60, 12'd3};
        for (int i = 0; i < rv_pkg::num_regs; i++)
            mregs[i] = '0;
        for (int i = 0; i < 64; i++)
            mram[i] = '0;
        alu_ri(rv_pkg::alu_add, 1, 0, 12'd1234);
        alu_ri(rv_pkg::alu_add, 2, 0, 12'hfb3);   // -77
        for (int k = 0; k < 10; k++) begin
            alu_rr(r_ops[k], 3, 2, 1);
            store_dword(3, 0, 12'(8 * k));
        end
        for (int k = 0; k < 9; k++) begin
            alu_ri(i_ops[k], 4, 2, i_imms[k]);
            store_dword(4, 0, 12'(80 + 8 * k));
        end
        // Distances 3, 2 and 1
        alu_ri(rv_pkg::alu_add, 5, 0, 12'd55);
        alu_ri(rv_pkg::alu_add, 6, 0, 12'd66);
        alu_ri(rv_pkg::alu_add, 7, 0, 12'd77);
        alu_rr(rv_pkg::alu_add, 8, 5, 6);
        alu_rr(rv_pkg::alu_sub, 9, 8, 7);
        store_dword(9, 0, 12'd160);
        store_dword(8, 0, 12'd168);
        // x0 as destination and source
        alu_ri(rv_pkg::alu_add, 0, 0, 12'd99);
        alu_rr(rv_pkg::alu_add, 10, 0, 1);
        store_dword(10, 0, 12'd176);
        store_dword(0, 0, 12'd184);
        // Load-use on ALU operand and on store data
        load_dword(11, 0, 12'd160);
        alu_rr(rv_pkg::alu_add, 12, 11, 1);
        store_dword(12, 0, 12'd192);
        load_dword(13, 0, 12'd168);
        store_dword(13, 0, 12'd200);
        exp_count = exp_data.size();
        prog_len = prog.size();
    endtask

    task automatic check_value(input string sig, input logic [63:0] got, input logic [63:0] want);
        checks++;
        assert (got === want) else begin
            $display("Error at %0t: %s is %h, expected %h", $time, sig, got, want);
            errors++;
        end
    endtask

    task automatic check_reset();
        check_value("dmem_read", {63'd0, dmem_read}, 64'd0);
        check_value("dmem_write", {63'd0, dmem_write}, 64'd0);
        check_value("imem_addr", imem_addr, 64'd0);
    endtask

    task automatic run_test(input string name, input logic rnd);
        int start_errors;
        start_errors = errors;
        @(posedge clk);
        rst_n        <= 1'b0;
        random_ready <= rnd;
        repeat (2) @(posedge clk);
        store_idx = 0;
        rst_n <= 1'b1;
        @(negedge clk);
        check_reset();
        wait (store_idx >= exp_count);
        tests_run++;
        if (errors == start_errors) begin
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errors - start_errors);
        end
    endtask

    // Outputs sampled at the falling edge, where they are settled
    always @(negedge clk) begin
        if (rst_n && waiting) begin
            check_value("dmem_addr", dmem_addr, held_addr);
            check_value("dmem_wdata", dmem_wdata, held_wdata);
            check_value("dmem_read", {63'd0, dmem_read}, {63'd0, held_read});
            check_value("dmem_write", {63'd0, dmem_write}, {63'd0, held_write});
        end
        if (rst_n && dmem_write && dmem_ready) begin
            if (store_idx < exp_count) begin
                check_value("dmem_addr", dmem_addr, exp_addr[store_idx]);
                check_value("dmem_wdata", dmem_wdata, exp_data[store_idx]);
            end else begin
                $display("Unexpected extra store to address %h at %0t", dmem_addr, $time);
                errors++;
            end
            store_idx++;
        end
        waiting    = rst_n && (dmem_read || dmem_write) && !dmem_ready;
        held_addr  = dmem_addr;
        held_wdata = dmem_wdata;
        held_read  = dmem_read;
        held_write = dmem_write;
    end

    initial begin
        rst_n        = 1'b0;
        random_ready = 1'b0;
        build_program();
        for (int i = 0; i < 64; i++)
            u_mem.load_rom(i, (i < prog_len) ? prog[i] : '0);
        run_test("ready tied high", 1'b0);
        run_test("random ready", 1'b1);
        $display("Summary: %0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Budget of 40 cycles per instruction, four times over
    initial begin
        wait (prog_len != 0);
        repeat (prog_len * 40 * 4) @(posedge clk);
        $display("Timeout: only %0d of %0d stores seen before the cycle limit",
                 store_idx, exp_count);
        $display("Checks failed");
        $finish;
    end

endmodule

/* tb/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model #(
    parameter int unsigned seed = 0
) (
    input  logic                      clk,
    input  logic                      random_ready,
    input  logic [rv_pkg::xlen-1:0]   imem_addr,
    output logic [rv_pkg::inst_w-1:0] imem_data,
    output logic                      imem_ready,
    input  logic [rv_pkg::xlen-1:0]   dmem_addr,
    input  logic [rv_pkg::xlen-1:0]   dmem_wdata,
    input  logic                      dmem_write,
    output logic [rv_pkg::xlen-1:0]   dmem_rdata,
    output logic                      dmem_ready
);

    logic [rv_pkg::inst_w-1:0] rom [64];
    logic [rv_pkg::xlen-1:0]   ram [64];

    // Zero words past the ROM decode as bubbles
    assign imem_data  = (imem_addr < 64'd256) ? rom[imem_addr[7:2]] : '0;
    assign dmem_rdata = ram[dmem_addr[8:3]];

    task automatic load_rom(input int idx, input logic [rv_pkg::inst_w-1:0] word);
        rom[idx] = word;
    endtask

    initial begin
        for (int i = 0; i < 64; i++)
            ram[i] = {32'hd00d0000 + 32'(i), ~(32'(i) * 32'h01010101)};
    end

    always @(posedge clk) begin
        if (dmem_write && dmem_ready)
            ram[dmem_addr[8:3]] <= dmem_wdata;
    end

    // Ready high about 70% of cycles in random mode
    initial begin
        int unsigned s;
        s = seed;
        imem_ready = 1'b0;
        dmem_ready = 1'b0;
        void'($urandom(s));
        forever begin
            @(posedge clk);
            imem_ready <= !random_ready || ($urandom % 10) < 7;
            dmem_ready <= !random_ready || ($urandom % 10) < 7;
        end
    end

endmodule
